/* Makefile */
# Verilator build and run of the emulation harness testbench

VERILATOR ?= verilator
TOP       ?= emu_harness_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_STR  ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* logic/emu_clock_gate.sv */
`timescale 1ns/1ps

module emu_clock_gate (
    input  logic host_clk,
    input  logic en,           // Sampled while host_clk low
    output logic gated_clk
);

    // Enable as seen by the high phase
    logic en_lat;

    // Transparent in the low phase only
    // Holds steady across the high phase so no runt pulse
    always_latch begin
        if (!host_clk) begin
            en_lat = en;
        end
    end

    // Full-width pulse on enabled cycles
    assign gated_clk = host_clk & en_lat;

endmodule

/* logic/emu_harness.sv */
`timescale 1ns/1ps

module emu_harness import emu_pkg::*; (
    input  logic               host_clk,
    input  logic               host_rst,

    output logic               target_clk,
    input  logic               target_rst,

    input  logic               do_pause,
    input  logic               do_resume,

    output logic               run_mode,
    input  logic               scan_mode,

    output logic               trig,

    // Flip-flop scan chain
    input  logic               ff_scan,
    input  logic               ff_dir,
    input  logic               ff_sdi,
    output logic               ff_sdo,

    // Cycle counter host port
    output logic [count_w-1:0] count,
    input  logic               count_write,
    input  logic [count_w-1:0] count_wdata,

    // Step limit host port
    input  logic               step_write,
    input  logic [count_w-1:0] step_wdata,
    output logic               step_trig
);

    logic tick;        // Target ready
    logic gate_en;     // Target clock enable

    // Target clock runs only on counted cycles
    assign gate_en = run_mode & tick;

    // Emulated design stand-in
    emu_target_model u_target (
        .host_clk   (host_clk),
        .host_rst   (host_rst),
        .target_rst (target_rst),
        .run_mode   (run_mode),
        .scan_mode  (scan_mode),
        .ff_scan    (ff_scan),
        .ff_dir     (ff_dir),
        .ff_sdi     (ff_sdi),
        .ff_sdo     (ff_sdo),
        .tick       (tick),
        .trig       (trig)
    );

    emu_clock_gate u_clk_gate (
        .host_clk   (host_clk),
        .en         (gate_en),
        .gated_clk  (target_clk)
    );

    // Pause, resume and counters
    emu_run_ctrl u_run_ctrl (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .tick        (tick),
        .trig        (trig),
        .do_pause    (do_pause),
        .do_resume   (do_resume),
        .count_write (count_write),
        .count_wdata (count_wdata),
        .step_write  (step_write),
        .step_wdata  (step_wdata),
        .run_mode    (run_mode),
        .step_trig   (step_trig),
        .count       (count)
    );

endmodule

/* logic/emu_pkg.sv */
package emu_pkg;

    // Host-side cycle and step counters
    localparam int count_w = 64;

    // Target flip-flop state, also the scan chain length
    localparam int state_w = 32;

    // State loaded on target reset
    localparam logic [state_w-1:0] lfsr_seed = 32'h5eed_1234;

    // Galois mask, right-shift form
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [state_w-1:0] lfsr_taps = 32'h8020_0003;

    // Trap point inside the target model
    localparam logic [state_w-1:0] trig_match = 32'h3c5a_96e1;

    // Host cycles per stall cycle
    // Last phase of each period has tick low
    localparam int tick_period = 4;

endpackage

/* logic/emu_run_ctrl.sv */
`timescale 1ns/1ps

module emu_run_ctrl import emu_pkg::*; (
    input  logic               host_clk,
    input  logic               host_rst,

    input  logic               tick,           // Target can advance
    input  logic               trig,           // Trap from target

    input  logic               do_pause,       // Host strobe, hold until tick
    input  logic               do_resume,      // Host strobe

    input  logic               count_write,
    input  logic [count_w-1:0] count_wdata,

    input  logic               step_write,
    input  logic [count_w-1:0] step_wdata,

    output logic               run_mode,
    output logic               step_trig,      // Step budget used up
    output logic [count_w-1:0] count
);

    // Remaining steps, zero means no limit
    logic [count_w-1:0] step;
    logic [count_w-1:0] step_next;

    // Counted target cycle
    logic               advance;

    // Stall and pause both freeze everything
    assign advance = run_mode && tick;

    // Cycle counter
    // Host write wins over counting
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            count <= '0;
        end else if (count_write) begin
            count <= count_wdata;
        end else if (advance) begin
            count <= count + 1'b1;     // Lands on the following cycle
        end
    end

    // Step counter register
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            step <= '0;
        end else begin
            step <= step_next;
        end
    end

    // Step next value
    always_comb begin
        if (step_write) begin
            step_next = step_wdata;    // Arm
        end else if (step == '0) begin
            step_next = '0;            // Idle, stays at zero
        end else if (advance) begin
            step_next = step - 1'b1;
        end else begin
            step_next = step;          // Stalled or paused
        end
    end

    // Single-cycle pulse on the nonzero to zero transition
    // Same cycle as the last counted step
    assign step_trig = (step != '0) && (step_next == '0);

    // Run mode
    // Stops only on a tick so the target is between cycles
    // Any stop cause beats a resume in the same cycle
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            run_mode <= 1'b1;          // Free running out of reset
        end else if ((trig || step_trig || do_pause) && tick) begin
            run_mode <= 1'b0;
        end else if (do_resume) begin
            run_mode <= 1'b1;
        end
    end

endmodule

/* logic/emu_target_model.sv */
`timescale 1ns/1ps

module emu_target_model import emu_pkg::*; (
    input  logic host_clk,
    input  logic host_rst,
    input  logic target_rst,   // Target state only

    input  logic run_mode,     // From run control
    input  logic scan_mode,    // Host owns the state

    input  logic ff_scan,      // Shift enable
    input  logic ff_dir,       // 1 shifts ff_sdi in, 0 loops back
    input  logic ff_sdi,
    output logic ff_sdo,

    output logic tick,         // Target may advance this cycle
    output logic trig          // Trap condition
);

    // Emulated flip-flops
    logic [state_w-1:0] state;
    logic [state_w-1:0] state_step;    // One LFSR step ahead
    logic [state_w-1:0] state_shift;   // One scan shift ahead
    logic               scan_in;

    // Stall pattern
    logic [$clog2(tick_period)-1:0] phase;
    logic                           phase_last;

    // Stall phase counter
    // Free running, independent of run_mode
    assign phase_last = (int'(phase) == tick_period - 1);

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            phase <= '0;
        end else if (phase_last) begin
            phase <= '0;               // Wrap
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Back-pressure stand-in
    assign tick = !phase_last;

    // Galois step
    // LSB out, mask folded back in
    always_comb begin
        state_step = state >> 1;
        if (state[0]) begin
            state_step = state_step ^ lfsr_taps;
        end
    end

    // Scan chain
    assign ff_sdo  = state[state_w-1];             // MSB first
    assign scan_in = ff_dir ? ff_sdi : ff_sdo;     // Loopback when ff_dir low
    assign state_shift = {state[state_w-2:0], scan_in};

    // State register
    // Scan wins over stepping
    always_ff @(posedge host_clk) begin
        if (target_rst) begin
            state <= lfsr_seed;
        end else if (scan_mode) begin
            if (ff_scan) begin
                state <= state_shift;  // One bit per host cycle
            end
        end else if (run_mode && tick) begin
            state <= state_step;       // Counted target cycle
        end
    end

    // Trap comparator
    // Combinational, seen by run control on the same tick
    assign trig = (state == trig_match);

endmodule

/* src.f */
logic/emu_pkg.sv
logic/emu_target_model.sv
logic/emu_clock_gate.sv
logic/emu_run_ctrl.sv
logic/emu_harness.sv
tb/emu_harness_tb.sv
tb/emu_harness_chk.sv

/* tb/emu_harness_chk.sv */
`timescale 1ns/1ps

module emu_harness_chk import emu_pkg::*; (
    input logic               host_clk,
    input logic               host_rst,
    input logic               tick,
    input logic               trig,
    input logic               do_pause,
    input logic               count_write,
    input logic               step_write,
    input logic               run_mode,
    input logic               step_trig,
    input logic [count_w-1:0] step,
    input logic [count_w-1:0] count,
    input logic               en,          // Gate enable
    input logic               gated_clk
);

    // Stop needs a tick and a cause
    assert property (@(posedge host_clk) disable iff (host_rst)
        $fell(run_mode) |-> $past(tick && (trig || step_trig || do_pause)))
        else $error("run_mode fell without tick and cause");

    // Paused counter holds
    assert property (@(posedge host_clk) disable iff (host_rst)
        (!run_mode && !count_write) |=> (count == $past(count)))
        else $error("count moved while paused");

    // Last step is a counted cycle, budget then empty
    assert property (@(posedge host_clk) disable iff (host_rst)
        (step_trig && !step_write && !count_write)
            |=> (step == '0) && (count == $past(count) + 1'b1))
        else $error("step_trig without a counted last step");

    // Rising target edge only with enable held
    assert property (@(posedge gated_clk) en)
        else $error("gated clock pulsed with enable low");

endmodule

bind emu_run_ctrl emu_harness_chk u_run_chk (
    .host_clk(host_clk), .host_rst(host_rst), .tick(tick), .trig(trig),
    .do_pause(do_pause), .count_write(count_write), .step_write(step_write),
    .run_mode(run_mode), .step_trig(step_trig), .step(step), .count(count),
    .en(1'b1), .gated_clk(1'b0)
);

bind emu_clock_gate emu_harness_chk u_gate_chk (
    .host_clk(host_clk), .host_rst(1'b1), .tick(1'b0), .trig(1'b0),
    .do_pause(1'b0), .count_write(1'b0), .step_write(1'b0), .run_mode(1'b0),
    .step_trig(1'b0), .step('0), .count('0),
    .en(en), .gated_clk(gated_clk)
);

/* tb/emu_harness_tb.sv */
`timescale 1ns/1ps

module emu_harness_tb import emu_pkg::*; ();

    localparam int max_step    = 40;
    localparam int cycle_limit = 8 + 60 + 3 * (max_step + 4 * tick_period)
                                 + 6 * (state_w + 4) + 16 * 4 * tick_period + 200;

    // DUT inputs
    logic host_clk, host_rst, target_rst;
    logic do_pause, do_resume, scan_mode;
    logic ff_scan, ff_dir, ff_sdi;
    logic count_write, step_write;
    logic [count_w-1:0] count_wdata, step_wdata;

    // DUT outputs
    logic target_clk, run_mode, trig, ff_sdo, step_trig;
    logic [count_w-1:0] count;

    // Reference model state
    int                 m_phase;
    logic [state_w-1:0] m_state;
    logic [count_w-1:0] m_count, m_step, m_step_nx;
    logic               m_run, m_tick, m_adv, m_stop;
    logic               gate_exp;      // Target clock enable for the next high phase

    int errors;
    int cycles;
    int trig_pulses;           // step_trig pulses seen

    emu_harness uut (.*);

    // Galois step, right shift with mask
    function automatic logic [state_w-1:0] lfsr_next(input logic [state_w-1:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    // Inverse step, mask MSB marks a folded bit
    function automatic logic [state_w-1:0] lfsr_prev(input logic [state_w-1:0] t);
        return t[state_w-1] ? (((t ^ lfsr_taps) << 1) | 1) : (t << 1);
    endfunction

    // Stall on last phase of each period
    function automatic logic tick_of(input int phase);
        return phase != tick_period - 1;
    endfunction

    // Step budget next value from current model and host inputs
    function automatic logic [count_w-1:0] step_after(input logic adv);
        if (step_write) return step_wdata;
        if (m_step == '0) return '0;
        return adv ? m_step - 64'd1 : m_step;
    endfunction

    task automatic check_count(input string name, input logic [count_w-1:0] exp,
                               input logic [count_w-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input logic [state_w-1:0] exp,
                               input logic [state_w-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            errors++;
            $display("** Error %s: expected %h, got %h", name, exp, act);
        end
    endtask

    initial begin
        host_clk = 1'b0;
        forever #10 host_clk = ~host_clk;
    end

    // Reference model, advanced on each rising edge
    always @(posedge host_clk) begin
        m_tick    = tick_of(m_phase);
        m_adv     = m_run && m_tick;
        m_step_nx = step_after(m_adv);
        m_stop    = m_tick && ((m_state == trig_match) || do_pause
                    || ((m_step != '0) && (m_step_nx == '0)));
        if (target_rst) m_state = lfsr_seed;
        else if (scan_mode) begin
            if (ff_scan) m_state = {m_state[state_w-2:0], ff_dir ? ff_sdi : m_state[state_w-1]};
        end else if (m_adv) m_state = lfsr_next(m_state);
        if (host_rst) begin
            m_phase = 0;
            m_count = '0;
            m_step  = '0;
            m_run   = 1'b1;
        end else begin
            m_phase = (m_phase == tick_period - 1) ? 0 : m_phase + 1;
            if (count_write) m_count = count_wdata;
            else if (m_adv) m_count = m_count + 64'd1;
            m_step = m_step_nx;
            if (m_stop) m_run = 1'b0;
            else if (do_resume) m_run = 1'b1;
        end
    end

    // Compare at the falling edge, all outputs settled
    always @(negedge host_clk) begin
        gate_exp = m_run && tick_of(m_phase);  // Latched by the gate during this low phase
        if (!host_rst) begin
            check_count("count", m_count, count);
            check_bit("run_mode", m_run, run_mode);
            check_bit("step_trig", (m_step != '0)
                      && (step_after(m_run && tick_of(m_phase)) == '0), step_trig);
            check_bit("ff_sdo", m_state[state_w-1], ff_sdo);
            check_bit("trig", m_state == trig_match, trig);
            if (step_trig) trig_pulses++;
        end
    end

    // Mid high phase, target_clk pulses only on counted cycles
    always @(posedge host_clk) begin
        #5;
        if (!host_rst) begin
            check_bit("target_clk", gate_exp, target_clk);
        end
    end

    // Run limit
    always @(posedge host_clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, test sequence did not finish", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic next_cycle(input int n);
        repeat (n) begin
            @(posedge host_clk);
            #1;
        end
    endtask

    // Wait for run_mode low, bounded
    task automatic wait_paused(input int limit, output int n);
        n = 0;
        while (run_mode && n < limit) begin
            next_cycle(1);
            n++;
        end
        if (run_mode) begin
            errors++;
            $display("Target did not pause within %0d cycles", limit);
        end
    endtask

    task automatic pause_target();
        int n;
        do_pause = 1'b1;
        wait_paused(4 * tick_period, n);
        do_pause = 1'b0;
        if (n > 2) begin
            errors++;
            $display("Pause took %0d cycles, more than 2", n);
        end
    endtask

    task automatic resume_target();
        do_resume = 1'b1;
        next_cycle(1);
        do_resume = 1'b0;
    endtask

    // Arm k steps and resume in one cycle
    task automatic step_run(input int unsigned k);
        logic [count_w-1:0] start;
        int n;
        step_write = 1'b1;
        step_wdata = count_w'(k);
        do_resume  = 1'b1;
        next_cycle(1);
        step_write = 1'b0;
        do_resume  = 1'b0;
        start       = count;
        trig_pulses = 0;
        wait_paused(2 * k + 4 * tick_period, n);
        check_count("count after steps", start + count_w'(k), count);
        if (trig_pulses != 1) begin
            errors++;
            $display("Expected one step_trig pulse for %0d steps, saw %0d", k, trig_pulses);
        end
    endtask

    // One full pass, MSB first
    task automatic scan_pass(input logic dir, input logic [state_w-1:0] win,
                             output logic [state_w-1:0] wout);
        ff_scan = 1'b1;
        ff_dir  = dir;
        for (int i = 0; i < state_w; i++) begin
            wout[state_w-1-i] = ff_sdo;
            ff_sdi = win[state_w-1-i];
            next_cycle(1);
        end
        ff_scan = 1'b0;
        ff_sdi  = 1'b0;
    endtask

    initial begin
        logic [count_w-1:0] frozen;
        logic [state_w-1:0] expect_w, got_w, rnd_w;
        int n;
        host_rst    = 1'b1;
        target_rst  = 1'b1;
        do_pause    = 1'b0;
        do_resume   = 1'b0;
        scan_mode   = 1'b0;
        ff_scan     = 1'b0;
        ff_dir      = 1'b0;
        ff_sdi      = 1'b0;
        count_write = 1'b0;
        step_write  = 1'b0;
        count_wdata = '0;
        step_wdata  = '0;
        errors      = 0;
        cycles      = 0;
        trig_pulses = 0;
        void'($urandom(32'h710f_f7e6));
        next_cycle(8);
        host_rst   = 1'b0;
        target_rst = 1'b0;

        // Reset values, then free run
        check_bit("run_mode", 1'b1, run_mode);
        check_count("count", '0, count);
        check_bit("step_trig", 1'b0, step_trig);
        next_cycle(20);

        // Pause freezes, resume continues
        pause_target();
        frozen = count;
        next_cycle(6);
        check_count("count frozen", frozen, count);
        resume_target();
        next_cycle(10);

        // Random step lengths
        for (int r = 0; r < 3; r++) begin
            pause_target();
            step_run(($urandom % max_step) + 1);
        end

        // Loopback read, twice, then shift-in of a random word
        scan_mode = 1'b1;
        expect_w  = m_state;
        scan_pass(1'b0, '0, got_w);
        check_state("scan loopback", expect_w, got_w);
        scan_pass(1'b0, '0, got_w);
        check_state("scan loopback again", expect_w, got_w);
        rnd_w = $urandom;
        scan_pass(1'b1, rnd_w, got_w);
        scan_pass(1'b0, '0, got_w);
        check_state("scan readback", rnd_w, got_w);
        scan_mode = 1'b0;
        resume_target();
        next_cycle(8);

        // Count host writes, one near wrap
        count_write = 1'b1;
        count_wdata = {$urandom, $urandom};
        next_cycle(1);
        count_write = 1'b0;
        next_cycle(10);
        count_write = 1'b1;
        count_wdata = 64'hffff_ffff_ffff_fffe;
        next_cycle(1);
        count_write = 1'b0;
        next_cycle(8);

        // Trap from the predecessor of the match value
        pause_target();
        scan_mode = 1'b1;
        scan_pass(1'b1, lfsr_prev(trig_match), got_w);
        scan_mode = 1'b0;
        check_bit("trig", 1'b0, trig);
        resume_target();
        n = 0;
        while (!trig && n < 4 * tick_period) begin
            next_cycle(1);
            n++;
        end
        check_bit("trig", 1'b1, trig);
        check_bit("run_mode at trig", 1'b1, run_mode);
        wait_paused(2, n);             // Stops on the next tick
        next_cycle(4);

        $display("Errors: %0d, cycles: %0d", errors, cycles);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
